//--- verilog/permPipe_cfg.svh
`ifndef PERM_PIPE_CFG_SVH
`define PERM_PIPE_CFG_SVH

// candidate and reference geometry
`define PERM_LANES 4
`define LANE_WIDTH 32

// result word fields, stamp:count:sum from msb down
`define STAMP_WIDTH 19
`define COUNT_WIDTH 5
`define SUM_WIDTH 40

// output FIFO sizing; threshold leaves room for decode and execute in flight
`define RESULT_FIFO_DEPTH 16
`define SLOW_THRESHOLD 12

`endif

//--- verilog/permPipePkg.sv
`include "permPipe_cfg.svh"

package permPipePkg;

    // one lane of top or bot, read as a bit set
    typedef logic [`LANE_WIDTH-1:0] laneT;

    // one bit per lane ordering, 4! = 24
    // bit 0 is the identity, the rest follow lexicographic order of source lanes
    typedef logic [23:0] permMaskT;

    // packed so that stamp lands in the top bits of the 64-bit word
    typedef struct packed {
        logic [`STAMP_WIDTH-1:0] stamp;
        logic [`COUNT_WIDTH-1:0] count;
        logic [`SUM_WIDTH-1:0]   sum;
    } resultWordT;

endpackage

//--- verilog/permResultIf.sv
`timescale 1ns/1ps
`include "permPipe_cfg.svh"

// execute to result buffer, valid is a one-cycle write strobe
interface permResultIf;

    logic                    valid;
    logic [`STAMP_WIDTH-1:0] stamp; // cycle count at registration
    logic [`COUNT_WIDTH-1:0] count; // valid orderings of this candidate
    logic [`SUM_WIDTH-1:0]   sum;   // running total including this count

    modport source (
        output valid,
        output stamp,
        output count,
        output sum
    );

    modport sink (
        input valid,
        input stamp,
        input count,
        input sum
    );

endinterface

//--- verilog/permuteDecode.sv
`timescale 1ns/1ps
`include "permPipe_cfg.svh"

module permuteDecode (
    input  logic                                 clock,
    input  logic                                 rstLocal,
    input  logic                                 ivalid,
    input  logic [`PERM_LANES*`LANE_WIDTH-1:0]  top,
    input  logic [`PERM_LANES*`LANE_WIDTH-1:0]  bot,
    input  logic                                 slow,
    output logic                                 oready,
    output logic                                 maskValid,
    output permPipePkg::permMaskT                mask
);

    import permPipePkg::*;

    laneT                  topLane [`PERM_LANES];
    laneT                  botLane [`PERM_LANES];
    logic [`PERM_LANES-1:0] fits [`PERM_LANES]; // fits[pos][src]: bot lane src fits top lane pos
    permMaskT              maskComb;
    logic                  accept;

    // throttling is decided in the result buffer
    assign oready = !slow;
    assign accept = ivalid && oready;

    // lane 0 sits in the low bits
    always_comb begin
        for (int pos = 0; pos < `PERM_LANES; pos++) begin
            topLane[pos] = top[pos*`LANE_WIDTH +: `LANE_WIDTH];
            botLane[pos] = bot[pos*`LANE_WIDTH +: `LANE_WIDTH];
        end
        for (int pos = 0; pos < `PERM_LANES; pos++) begin
            for (int src = 0; src < `PERM_LANES; src++) begin
                fits[pos][src] = ((botLane[src] & ~topLane[pos]) == '0); // subset test
            end
        end
    end

    // walk the source index tuples in lexicographic order, skipping repeats
    always_comb begin
        int idx;
        idx = 0;
        maskComb = '0;
        for (int a = 0; a < `PERM_LANES; a++) begin
            for (int b = 0; b < `PERM_LANES; b++) begin
                for (int c = 0; c < `PERM_LANES; c++) begin
                    for (int d = 0; d < `PERM_LANES; d++) begin
                        if (a != b && a != c && a != d && b != c && b != d && c != d) begin
                            maskComb[idx] = fits[0][a] & fits[1][b] & fits[2][c] & fits[3][d];
                            idx++;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rstLocal) begin
            maskValid <= 1'b0;
        end else begin
            maskValid <= accept; // one pulse per candidate
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            mask <= maskComb;
        end
    end

    // a refused candidate must not show up downstream
    refusedNotDecoded: assert property (@(posedge clock) disable iff (rstLocal)
        (ivalid && !oready) |=> !maskValid);

endmodule

//--- verilog/permuteAccumulate.sv
`timescale 1ns/1ps
`include "permPipe_cfg.svh"

module permuteAccumulate (
    input  logic                  clock,
    input  logic                  rstLocal,
    input  logic                  maskValid,
    input  permPipePkg::permMaskT mask,
    permResultIf.source           res
);

    logic [`STAMP_WIDTH-1:0] cycleCount; // free running, wraps
    logic [`COUNT_WIDTH-1:0] maskCount;
    logic [`SUM_WIDTH-1:0]   runSum;

    // population count of the ordering mask
    always_comb begin
        maskCount = '0;
        for (int i = 0; i < $bits(mask); i++) begin
            maskCount = maskCount + {{(`COUNT_WIDTH-1){1'b0}}, mask[i]};
        end
    end

    always_ff @(posedge clock) begin
        if (rstLocal) begin
            cycleCount <= '0;
            runSum     <= '0;
            res.valid  <= 1'b0;
        end else begin
            cycleCount <= cycleCount + 1'b1;
            res.valid  <= maskValid;
            if (maskValid) begin
                runSum <= runSum + {{(`SUM_WIDTH-`COUNT_WIDTH){1'b0}}, maskCount};
            end
        end
    end

    // stamp takes the counter value seen on the registering edge
    always_ff @(posedge clock) begin
        if (maskValid) begin
            res.stamp <= cycleCount;
            res.count <= maskCount;
        end
    end

    assign res.sum = runSum; // already includes the new count when valid is high

    // 24 orderings at most, so anything above means the mask path is broken
    countInRange: assert property (@(posedge clock) disable iff (rstLocal)
        res.valid |-> (res.count <= 5'd24));

endmodule

//--- verilog/resultBuffer.sv
`timescale 1ns/1ps
`include "permPipe_cfg.svh"

module resultBuffer (
    input  logic                                       clock,
    input  logic                                       rstLocal,
    permResultIf.sink                                  res,
    input  logic                                       iready,
    output logic                                       ovalid,
    output logic [$bits(permPipePkg::resultWordT)-1:0] resultOut,
    output logic                                       slow
);

    import permPipePkg::*;

    localparam int addrWidth = $clog2(`RESULT_FIFO_DEPTH);
    localparam logic [addrWidth:0] slowLevel = `SLOW_THRESHOLD;
    localparam logic [addrWidth:0] fullLevel = `RESULT_FIFO_DEPTH;

    resultWordT             mem [`RESULT_FIFO_DEPTH];
    logic [addrWidth-1:0]   wrPtr; // pointers wrap on their own, depth is a power of two
    logic [addrWidth-1:0]   rdPtr;
    logic [addrWidth:0]     fillCount;
    logic [addrWidth:0]     fillNext;
    logic [addrWidth:0]     fillAfterPop;
    logic                   pop;

    assign pop          = ovalid && iready;
    assign fillAfterPop = fillCount - {{addrWidth{1'b0}}, pop};
    assign fillNext     = fillAfterPop + {{addrWidth{1'b0}}, res.valid};

    // write side has no ready, slow keeps us from overrunning
    always_ff @(posedge clock) begin
        if (res.valid) begin
            mem[wrPtr] <= {res.stamp, res.count, res.sum};
        end
    end

    always_ff @(posedge clock) begin
        if (rstLocal) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            fillCount <= '0;
            ovalid    <= 1'b0;
            slow      <= 1'b0;
        end else begin
            if (res.valid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            fillCount <= fillNext;
            // a word written this edge is offered one edge later
            ovalid    <= (fillAfterPop != '0);
            slow      <= (fillNext >= slowLevel);
        end
    end

    assign resultOut = mem[rdPtr]; // show-ahead

    // slow must stop acceptance early enough to cover the two stages in flight
    noWriteWhenFull: assert property (@(posedge clock) disable iff (rstLocal)
        res.valid |-> (fillCount < fullLevel));

    emptyMeansIdle: assert property (@(posedge clock) disable iff (rstLocal)
        (fillCount == '0) |-> !ovalid);

endmodule

//--- verilog/permPipeTop.sv
`timescale 1ns/1ps
`include "permPipe_cfg.svh"

module permPipeTop (
    input  logic                                       clock,
    input  logic                                       rstLocal,
    input  logic                                       ivalid,
    output logic                                       oready,
    input  logic [`PERM_LANES*`LANE_WIDTH-1:0]         top, // constant during a run
    input  logic [`PERM_LANES*`LANE_WIDTH-1:0]         bot,
    input  logic                                       iready,
    output logic                                       ovalid,
    output logic [$bits(permPipePkg::resultWordT)-1:0] resultOut
);

    import permPipePkg::*;

    logic     maskValid;
    permMaskT mask;
    logic     slow; // fifo near full, holds off new candidates

    permResultIf resIf ();

    permuteDecode u_permuteDecode (
        .clock     (clock),
        .rstLocal  (rstLocal),
        .ivalid    (ivalid),
        .top       (top),
        .bot       (bot),
        .slow      (slow),
        .oready    (oready),
        .maskValid (maskValid),
        .mask      (mask)
    );

    permuteAccumulate u_permuteAccumulate (
        .clock     (clock),
        .rstLocal  (rstLocal),
        .maskValid (maskValid),
        .mask      (mask),
        .res       (resIf.source)
    );

    resultBuffer u_resultBuffer (
        .clock     (clock),
        .rstLocal  (rstLocal),
        .res       (resIf.sink),
        .iready    (iready),
        .ovalid    (ovalid),
        .resultOut (resultOut),
        .slow      (slow)
    );

endmodule

//--- testbench/permPipeChecker.sv
`timescale 1ns/1ps
`include "permPipe_cfg.svh"

module permPipeChecker (
    input  logic                                       clock,
    input  logic                                       rstLocal,
    input  logic                                       ivalid,
    input  logic                                       oready,
    input  logic                                       iready,
    input  logic                                       ovalid,
    input  logic [$bits(permPipePkg::resultWordT)-1:0] resultOut,
    input  logic [`COUNT_WIDTH-1:0]                    expCount, // count for the line on ivalid
    input  logic                                       stallPhase,
    output int                                         passCount,
    output int                                         failCount,
    output int                                         doneCount
);

    import permPipePkg::*;

    logic [`COUNT_WIDTH-1:0] expQueue [$]; // accepted candidates waiting for a result
    logic [`SUM_WIDTH-1:0]   expSum;
    logic [`STAMP_WIDTH-1:0] lastStamp;
    logic                    haveStamp;
    logic                    inReset;
    logic                    sawThrottle;
    logic                    stallSeen;

    // mid-cycle sample, both handshakes are settled for the next rising edge
    always @(negedge clock) begin
        resultWordT              word;
        logic [`COUNT_WIDTH-1:0] want;
        logic                    bad;
        word = resultOut;
        if (rstLocal) begin
            inReset     = 1'b1;
            expSum      = '0;
            haveStamp   = 1'b0;
            sawThrottle = 1'b0;
            stallSeen   = 1'b0;
            expQueue.delete();
        end else begin
            if (inReset) begin
                if (ovalid !== 1'b0 || oready !== 1'b1) begin
                    $display("%0t: after reset ovalid should be low and oready high, got %b and %b",
                             $time, ovalid, oready);
                    failCount++;
                end
                inReset = 1'b0;
            end
            if (ivalid && oready) begin
                expQueue.push_back(expCount);
            end
            if (stallPhase && !oready) begin
                sawThrottle = 1'b1;
            end
            if (stallSeen && !stallPhase && !sawThrottle) begin
                $display("%0t: oready never dropped while the output was stalled", $time);
                failCount++;
            end
            stallSeen = stallPhase;
            if (ovalid && iready) begin
                if (expQueue.size() == 0) begin
                    $display("%0t: result word arrived with no accepted candidate pending", $time);
                    failCount++;
                end else begin
                    want   = expQueue.pop_front();
                    expSum = expSum + {{(`SUM_WIDTH-`COUNT_WIDTH){1'b0}}, want};
                    bad    = 1'b0;
                    if (word.count !== want) begin
                        $display("mismatch at %0t: count expected %0d actual %0d",
                                 $time, want, word.count);
                        bad = 1'b1;
                    end
                    if (word.sum !== expSum) begin
                        $display("mismatch at %0t: sum expected %0d actual %0d",
                                 $time, expSum, word.sum);
                        bad = 1'b1;
                    end
                    if (haveStamp && word.stamp <= lastStamp) begin
                        $display("%0t: stamp %0d did not increase past %0d",
                                 $time, word.stamp, lastStamp);
                        bad = 1'b1;
                    end
                    lastStamp = word.stamp;
                    haveStamp = 1'b1;
                    doneCount++;
                    if (bad) begin
                        failCount++;
                        $display("test %0d failed", doneCount);
                    end else begin
                        passCount++;
                        $display("test %0d passed, count %0d sum %0d", doneCount, want, expSum);
                    end
                end
            end
        end
    end

endmodule

//--- testbench/permPipeTb.sv
`timescale 1ns/1ps
`include "permPipe_cfg.svh"

module permPipeTb;

    localparam int numTests   = 16;
    localparam int numRuns    = 3; // full speed, random back-pressure, stall
    localparam int totalTests = numTests * numRuns;
    localparam int laneBits   = `PERM_LANES * `LANE_WIDTH;
    localparam int stallLen   = 20;

    logic                                       clock = 1'b0;
    logic                                       rstLocal;
    logic                                       ivalid;
    logic                                       oready;
    logic                                       iready;
    logic                                       ovalid;
    logic [laneBits-1:0]                        top;
    logic [laneBits-1:0]                        bot;
    logic [$bits(permPipePkg::resultWordT)-1:0] resultOut;
    logic [`COUNT_WIDTH-1:0]                    expCount;
    logic [laneBits-1:0]                        testMem [3*numTests]; // top, bot, count per line
    logic [1:0]                                 readyMode; // 0 ready, 1 random, 2 stall first
    logic                                       stallPhase;
    logic [31:0]                                rngState;
    int                                         stallCycles;
    int                                         passCount;
    int                                         failCount;
    int                                         doneCount;

    always #10 clock = ~clock;

    permPipeTop u_permPipeTop (
        .clock     (clock),
        .rstLocal  (rstLocal),
        .ivalid    (ivalid),
        .oready    (oready),
        .top       (top),
        .bot       (bot),
        .iready    (iready),
        .ovalid    (ovalid),
        .resultOut (resultOut)
    );

    permPipeChecker u_permPipeChecker (
        .clock      (clock),
        .rstLocal   (rstLocal),
        .ivalid     (ivalid),
        .oready     (oready),
        .iready     (iready),
        .ovalid     (ovalid),
        .resultOut  (resultOut),
        .expCount   (expCount),
        .stallPhase (stallPhase),
        .passCount  (passCount),
        .failCount  (failCount),
        .doneCount  (doneCount)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // output back-pressure, changes just after the rising edge
    initial begin
        iready      = 1'b0;
        stallPhase  = 1'b0;
        stallCycles = 0;
        rngState    = 32'h81ee_68e3;
        forever begin
            @(posedge clock);
            #1;
            rngState = lcgNext(rngState);
            if (readyMode == 2'd2 && stallCycles < stallLen) begin
                iready     = 1'b0;
                stallPhase = 1'b1;
                stallCycles++;
            end else begin
                stallPhase = 1'b0;
                if (readyMode == 2'd0) begin
                    iready = 1'b1;
                end else begin
                    iready = (rngState[31:24] >= 8'd102); // low about 40 %
                end
            end
        end
    end

    // present one line and hold it until the accepting edge
    task automatic sendLine(input int line);
        logic taken;
        top      = testMem[3*line];
        bot      = testMem[3*line+1];
        expCount = testMem[3*line+2][`COUNT_WIDTH-1:0];
        ivalid   = 1'b1;
        do begin
            taken = oready; // stable until the next rising edge
            @(posedge clock);
            #1;
        end while (!taken);
    endtask

    initial begin
        rstLocal  = 1'b1;
        ivalid    = 1'b0;
        top       = '0;
        bot       = '0;
        expCount  = '0;
        readyMode = 2'd0;
        $readmemh("testbench/permPipe_testdata.txt", testMem);
        repeat (5) @(posedge clock);
        #1;
        rstLocal = 1'b0;
        repeat (2) @(posedge clock); // checker looks at the idle outputs here
        #1;
        for (int i = 0; i < numTests; i++) begin
            sendLine(i);
        end
        ivalid    = 1'b0;
        readyMode = 2'd1;
        for (int i = 0; i < numTests; i++) begin
            sendLine(i);
        end
        ivalid = 1'b0;
        wait (doneCount == 2 * numTests); // drain before the stall run
        @(posedge clock);
        #1;
        readyMode = 2'd2;
        for (int i = 0; i < numTests; i++) begin
            sendLine(i);
        end
        ivalid = 1'b0;
        wait (doneCount == totalTests);
        repeat (10) @(posedge clock); // any extra word would show up here
        $display("closing: %0d tests passed, %0d failed", passCount, failCount);
        if (failCount == 0 && doneCount == totalTests) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        repeat (totalTests * 40 + 200) @(posedge clock);
        $display("watchdog expired, only %0d of %0d results arrived", doneCount, totalTests);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- testbench/permPipe_testdata.txt
// columns: top (lane 3 .. lane 0), bot (lane 3 .. lane 0), expected ordering count in hex
// each 128-bit word holds four 32-bit lanes, lane 0 in the low bits
ffffffffffffffffffffffffffffffff 00000000000000000000000000000000 18
ffffffffffffffffffffffffffffffff ffffffffffffffffffffffffffffffff 18
00000000000000000000000000000000 00000001000000010000000100000001 00
00000008000000040000000200000001 00000008000000040000000200000001 01
00000008000000040000000200000001 00000001000000020000000400000008 01
0000000c0000000c0000000300000003 00000008000000040000000200000001 04
000000000000000f0000000f0000000f 00000004000000020000000100000000 06
0000ffff0000ffff0000ffffffffffff 00000001000000010000000100010000 06
0000000000000000ffffffffffffffff 00000000000000009abcdef012345678 04
00000000000000000000000000000000 00000000000000000000000000000000 18
0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f 00000000f00000000000000000000000 00
0000000f000000070000000300000001 00000007000000030000000100000001 08
0000000f000000070000000300000001 0000000100000001000000010000000f 06
0000000f000000070000000300000001 0000000f000000070000000300000001 01
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 5a000000a000000000000005a5a5a5a5 00
00ff00ffffffffffffffffffffffffff 00010000000000010000ff00ff000000 0c

//--- verilog.f
+incdir+verilog
verilog/permPipePkg.sv
verilog/permResultIf.sv
verilog/permuteDecode.sv
verilog/permuteAccumulate.sv
verilog/resultBuffer.sv
verilog/permPipeTop.sv
testbench/permPipeChecker.sv
testbench/permPipeTb.sv

//--- run.sh
#!/bin/sh
# builds and runs the permutation pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module permPipeTb \
    -f verilog.f -o permPipeSim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/permPipeSim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
